// File: Makefile
# Verilator build for the cpuCore testbench

TOP = cpuCoreBench

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f all.f \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+source
source/cpuTypesPkg.sv
source/controlPkg.sv
source/registerFile.sv
source/aluUnit.sv
source/memoryInterface.sv
source/stepCounter.sv
source/busDatapath.sv
source/controlSequencer.sv
source/cpuCore.sv
bench/cpuCoreBench.sv

// File: bench/cpuCoreBench.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpuCoreBench;

	localparam int memWords = 1 << `CPU_ADDR_WIDTH;
	localparam int countIndex = memWords;  // Expected store count sits right after the image
	localparam int pairBase = memWords + 1;
	localparam logic [4:0] ldCode = 5'b00000;
	localparam logic [4:0] haltCode = 5'b11011;

	logic Clock = 1'b0;
	logic rstN = 1'b0;
	logic memAck = 1'b0;
	cpuTypesPkg::word memReadData = '0;
	logic memReq;
	logic memWrite;
	cpuTypesPkg::memAddr memAddr;
	cpuTypesPkg::word memWriteData;
	logic halted;

	cpuTypesPkg::word testData [0:2*memWords-1];
	cpuTypesPkg::word memImage [0:memWords-1];
	logic [31:0] lcgState = 32'h93e3_a444;
	int ackDelay = 0;
	int storeCount = 0;
	logic haltFetched = 1'b0;

	// Monitor state
	logic prevReq = 1'b0;
	logic ackSeen = 1'b0;
	logic reqWrite;
	cpuTypesPkg::memAddr reqAddr;
	cpuTypesPkg::word reqData;
	cpuTypesPkg::memAddr fetchAddr = '0;
	cpuTypesPkg::memAddr loadAddr = '0;
	logic loadPending = 1'b0;

	always #20 Clock = ~Clock;

	cpuCore dut_i (
		.Clock(Clock), .rstN(rstN), .memReq(memReq), .memWrite(memWrite),
		.memAddr(memAddr), .memWriteData(memWriteData), .memAck(memAck),
		.memReadData(memReadData), .halted(halted)
	);

	// ############################################################
	// Failure reporting and compares

	task automatic abortRun(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkAddress(input string name, input cpuTypesPkg::memAddr actual,
			input cpuTypesPkg::memAddr expected);
		if (actual !== expected)
			abortRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	task automatic checkWord(input string name, input cpuTypesPkg::word actual,
			input cpuTypesPkg::word expected);
		if (actual !== expected)
			abortRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			abortRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
	endtask

	// LCG draw of a handshake delay between 0 and 5 cycles
	function automatic int randomDelay();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return int'((lcgState >> 16) % 32'd6);
	endfunction

	// ############################################################
	// Memory model

	always @(posedge Clock) begin
		if (!rstN) begin
			memAck <= 1'b0;
			memReadData <= '0;
		end else if (memReq && !memAck) begin
			if (ackDelay == 0) begin
				memAck <= 1'b1;
				if (memWrite)
					memImage[memAddr] = memWriteData;
				else
					memReadData <= memImage[memAddr];
				ackDelay = randomDelay();  // Used for the release that follows
			end else begin
				ackDelay--;
			end
		end else if (!memReq && memAck) begin
			if (ackDelay == 0) begin
				memAck <= 1'b0;
				ackDelay = randomDelay();
			end else begin
				ackDelay--;
			end
		end
	end

	// ############################################################
	// Protocol monitor and access checks

	task automatic handleAccess();
		cpuTypesPkg::word fetched;
		if (haltFetched) begin
			abortRun("memory request after the halt instruction was fetched");
		end else if (memWrite) begin
			if (loadPending)
				abortRun("write access where the data read of a load was expected");
			else if (storeCount >= int'(testData[countIndex]))
				abortRun("more stores than the data file lists");
			else begin
				checkAddress("memAddr", memAddr, testData[pairBase + 2*storeCount][7:0]);
				checkWord("memWriteData", memWriteData, testData[pairBase + 2*storeCount + 1]);
				storeCount++;
			end
		end else if (loadPending) begin
			checkAddress("memAddr", memAddr, loadAddr);  // Data read of ld
			loadPending = 1'b0;
		end else begin
			checkAddress("memAddr", memAddr, fetchAddr);
			fetched = memImage[fetchAddr];
			fetchAddr++;
			if (fetched[31:27] == ldCode) begin
				loadPending = 1'b1;
				loadAddr = fetched[7:0];
			end
			if (fetched[31:27] == haltCode)
				haltFetched <= 1'b1;
		end
	endtask

	always @(posedge Clock) begin
		if (!rstN) begin
			prevReq = 1'b0;
		end else begin
			if (!prevReq && memReq) begin
				if (memAck)
					abortRun("memReq rose while memAck was still high");
				ackSeen = 1'b0;
				reqAddr = memAddr;
				reqWrite = memWrite;
				reqData = memWriteData;
				handleAccess();
			end else if (prevReq && memReq) begin
				checkAddress("memAddr", memAddr, reqAddr);
				checkFlag("memWrite", memWrite, reqWrite);
				checkWord("memWriteData", memWriteData, reqData);
			end else if (prevReq && !memReq && !ackSeen) begin
				abortRun("memReq fell before memAck rose");
			end
			if (memReq && memAck)
				ackSeen = 1'b1;
			prevReq = memReq;
		end
	end

	// ############################################################
	// Main sequence

	initial begin
		int waitCycles;
		for (int i = 0; i < 2*memWords; i++)
			testData[i] = 32'hA5C3_0000 | 32'(i);
		$readmemh("bench/cpu_tests.mem", testData);
		for (int i = 0; i < memWords; i++)
			memImage[i] = testData[i];
		ackDelay = randomDelay();

		for (int cycle = 0; cycle < 8; cycle++) begin
			@(posedge Clock);
			if (cycle > 0) begin  // Outputs are unknown before the first edge
				checkFlag("memReq", memReq, 1'b0);
				checkFlag("halted", halted, 1'b0);
			end
			if (cycle == 7)
				rstN <= 1'b1;
		end
		@(posedge Clock);
		checkFlag("memReq", memReq, 1'b0);
		checkFlag("halted", halted, 1'b0);

		waitCycles = 0;
		while (!haltFetched && waitCycles < 4000) begin
			@(posedge Clock);
			waitCycles++;
		end
		if (!haltFetched)
			abortRun("timeout waiting for the halt instruction to be fetched");

		waitCycles = 0;
		while (halted !== 1'b1 && waitCycles < 60) begin
			@(posedge Clock);
			waitCycles++;
		end
		if (halted !== 1'b1)
			abortRun("halted did not rise within 60 cycles of the halt fetch");

		// The core must stay quiet once halted
		repeat (50) begin
			@(posedge Clock);
			checkFlag("memReq", memReq, 1'b0);
			checkFlag("halted", halted, 1'b1);
		end
		checkWord("store count", cpuTypesPkg::word'(storeCount), testData[countIndex]);

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: bench/cpu_tests.mem
// Words 0..255 are the memory image, word 256 is the expected store count,
// then each pair of words is a store address followed by its data
@000
00800040 01000041 09807FFD 0A000004  // ld r1, ld r2, ldi r3 -3, ldi r4 4
1A890000 12800080                    // add r5 r1 r2 and store
23098000 13000081                    // sub r6 r1 r3
2B890000 13800082                    // and r7 r1 r2
34090000 14000083                    // or r8 r1 r2
3C8A0000 14800084                    // shr r9 r1 r4
45120000 15000085                    // shl r10 r2 r4
11800086 10800087                    // Store the ldi and ld results
0E000021 3D9E0000 15800088           // Shift count 33 keeps only its low five bits
D8000000                             // halt
@040
12345678 0F0F00FF
@100
00000009
00000080 21435777 00000081 1234567B 00000082 02040078
00000083 1F3F56FF 00000084 01234567 00000085 F0F00FF0
00000086 FFFFFFFD 00000087 12345678 00000088 7FFFFFFE

// File: source/aluUnit.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module aluUnit (
	input  logic Clock,
	input  logic rstN,
	input  cpuTypesPkg::word busIn,
	input  logic yIn,
	input  logic zIn,
	input  controlPkg::aluOp op,
	output cpuTypesPkg::word zOut
);

	cpuTypesPkg::word yReg;
	cpuTypesPkg::word result;
	logic [$clog2(`CPU_WORD_WIDTH)-1:0] shiftAmount;

	assign shiftAmount = busIn[$clog2(`CPU_WORD_WIDTH)-1:0];  // Only the low bits count

	// Y holds the first operand across steps
	always_ff @(posedge Clock) begin
		if (yIn)
			yReg <= busIn;
	end

	always_comb begin
		case (op)
			controlPkg::aluInc: result = busIn + 1'b1;  // Next PC during fetch
			controlPkg::aluAdd: result = yReg + busIn;
			controlPkg::aluSub: result = yReg - busIn;
			controlPkg::aluAnd: result = yReg & busIn;
			controlPkg::aluOr:  result = yReg | busIn;
			controlPkg::aluShr: result = yReg >> shiftAmount;
			controlPkg::aluShl: result = yReg << shiftAmount;
			default:            result = busIn;
		endcase
	end

	// Z register
	always_ff @(posedge Clock) begin
		if (!rstN)
			zOut <= '0;
		else if (zIn)
			zOut <= result;
	end

endmodule

// File: source/busDatapath.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module busDatapath (
	input  logic Clock,
	input  logic rstN,
	input  controlPkg::busSource busSel,
	input  controlPkg::regField regSel,
	input  logic regIn,
	input  logic yIn,
	input  logic zIn,
	input  logic pcIn,
	input  logic irIn,
	input  controlPkg::aluOp aluSel,
	input  cpuTypesPkg::word mdrValue,
	output cpuTypesPkg::word busValue,
	output cpuTypesPkg::opcode currentOp
);

	cpuTypesPkg::word pc;
	cpuTypesPkg::word ir;
	cpuTypesPkg::word immValue;
	cpuTypesPkg::word regValue;
	cpuTypesPkg::word zValue;
	cpuTypesPkg::regIndex regNumber;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pcIn)
				pc <= busValue;
			if (irIn)
				ir <= busValue;
		end
	end

	// Register number comes from the IR field the sequencer asks for
	always_comb begin
		case (regSel)
			controlPkg::fieldRb: regNumber = ir[22:19];
			controlPkg::fieldRc: regNumber = ir[18:15];
			default:             regNumber = ir[26:23];
		endcase
	end

	assign immValue = {{(`CPU_WORD_WIDTH-15){ir[14]}}, ir[14:0]};
	assign currentOp = cpuTypesPkg::opcode'(ir[31:27]);

	// ############################################################
	// Bus multiplexer

	always_comb begin
		case (busSel)
			controlPkg::busReg: busValue = regValue;
			controlPkg::busPc:  busValue = pc;
			controlPkg::busZ:   busValue = zValue;
			controlPkg::busMdr: busValue = mdrValue;
			controlPkg::busImm: busValue = immValue;
			default:            busValue = '0;
		endcase
	end

	registerFile regs_i (
		.Clock(Clock), .rstN(rstN),
		.readIndex(regNumber), .writeIndex(regNumber), .writeEnable(regIn),
		.writeData(busValue), .readData(regValue)
	);

	aluUnit alu_i (
		.Clock(Clock), .rstN(rstN), .busIn(busValue),
		.yIn(yIn), .zIn(zIn), .op(aluSel), .zOut(zValue)
	);

endmodule

// File: source/controlPkg.sv
package controlPkg;

	typedef enum logic [1:0] {
		seqRun,
		seqMemWait,  // Step counter frozen until the memory port finishes
		seqHalted
	} seqState;

	typedef logic [2:0] tStep;

	localparam tStep T0 = 3'd0;
	localparam tStep T1 = 3'd1;
	localparam tStep T2 = 3'd2;
	localparam tStep T3 = 3'd3;
	localparam tStep T4 = 3'd4;
	localparam tStep T5 = 3'd5;

	typedef enum logic [2:0] {busNone, busReg, busPc, busZ, busMdr, busImm} busSource;

	// Which IR field names the register on the bus
	typedef enum logic [1:0] {fieldRa, fieldRb, fieldRc} regField;

	typedef enum logic [2:0] {
		aluPass, aluInc, aluAdd, aluSub, aluAnd, aluOr, aluShr, aluShl
	} aluOp;

endpackage

// File: source/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
	input  logic Clock,
	input  logic rstN,
	input  controlPkg::tStep step,
	input  cpuTypesPkg::opcode currentOp,
	input  logic memDone,
	output controlPkg::busSource busSel,
	output controlPkg::regField regSel,
	output controlPkg::aluOp aluSel,
	output logic regIn,
	output logic yIn,
	output logic zIn,
	output logic pcIn,
	output logic irIn,
	output logic marIn,
	output logic mdrLoadBus,
	output logic memStart,
	output logic memWrite,
	output logic advance,
	output logic clear,
	output logic halted
);

	controlPkg::seqState state;
	controlPkg::seqState nextState;
	controlPkg::aluOp opAlu;
	logic isRegOp;
	logic lastStep;  // Final step of the current instruction

	always_comb begin
		isRegOp = 1'b1;
		case (currentOp)
			cpuTypesPkg::opSub: opAlu = controlPkg::aluSub;
			cpuTypesPkg::opAnd: opAlu = controlPkg::aluAnd;
			cpuTypesPkg::opOr:  opAlu = controlPkg::aluOr;
			cpuTypesPkg::opShr: opAlu = controlPkg::aluShr;
			cpuTypesPkg::opShl: opAlu = controlPkg::aluShl;
			cpuTypesPkg::opAdd: opAlu = controlPkg::aluAdd;
			default: begin
				opAlu = controlPkg::aluAdd;
				isRegOp = 1'b0;
			end
		endcase
	end

	// ############################################################
	// Strobe pattern per step

	always_comb begin
		busSel = controlPkg::busNone;
		regSel = controlPkg::fieldRa;
		aluSel = controlPkg::aluPass;
		{regIn, yIn, zIn, pcIn, irIn} = 5'b0;
		{marIn, mdrLoadBus, memStart, memWrite} = 4'b0;
		lastStep = 1'b0;
		case (step)
			controlPkg::T0: begin
				busSel = controlPkg::busPc;
				marIn = 1'b1;
				zIn = 1'b1;
				aluSel = controlPkg::aluInc;
			end
			controlPkg::T1: begin
				busSel = controlPkg::busZ;
				pcIn = 1'b1;
				memStart = 1'b1;  // Instruction fetch
			end
			controlPkg::T2: begin
				busSel = controlPkg::busMdr;
				irIn = 1'b1;
			end
			controlPkg::T3: begin
				if (isRegOp) begin
					busSel = controlPkg::busReg;
					regSel = controlPkg::fieldRb;
					yIn = 1'b1;
				end else begin
					case (currentOp)
						cpuTypesPkg::opLdi: begin
							busSel = controlPkg::busImm;
							regIn = 1'b1;
							lastStep = 1'b1;
						end
						cpuTypesPkg::opLd: begin
							busSel = controlPkg::busImm;
							marIn = 1'b1;
							memStart = 1'b1;
						end
						cpuTypesPkg::opSt: begin
							busSel = controlPkg::busReg;
							mdrLoadBus = 1'b1;
						end
						default: lastStep = 1'b1;  // Halt and unknown codes
					endcase
				end
			end
			controlPkg::T4: begin
				if (isRegOp) begin
					busSel = controlPkg::busReg;
					regSel = controlPkg::fieldRc;
					zIn = 1'b1;
					aluSel = opAlu;
				end else if (currentOp == cpuTypesPkg::opSt) begin
					busSel = controlPkg::busImm;
					marIn = 1'b1;
					memStart = 1'b1;
					memWrite = 1'b1;
					lastStep = 1'b1;
				end else begin
					busSel = controlPkg::busMdr;  // Load result into Ra
					regIn = 1'b1;
					lastStep = 1'b1;
				end
			end
			default: begin
				busSel = controlPkg::busZ;
				regIn = 1'b1;
				lastStep = 1'b1;
			end
		endcase
		if (state != controlPkg::seqRun) begin
			{regIn, yIn, zIn, pcIn, irIn} = 5'b0;
			{marIn, mdrLoadBus, memStart, memWrite} = 4'b0;
		end
	end

	always_comb begin
		nextState = state;
		advance = 1'b0;
		clear = 1'b0;
		case (state)
			controlPkg::seqRun: begin
				if (step == controlPkg::T3 && currentOp == cpuTypesPkg::opHalt) begin
					nextState = controlPkg::seqHalted;
					clear = 1'b1;
				end else if (memStart) begin
					nextState = controlPkg::seqMemWait;
				end else begin
					clear = lastStep;
					advance = !lastStep;
				end
			end
			controlPkg::seqMemWait: if (memDone) begin
				nextState = controlPkg::seqRun;
				clear = lastStep;
				advance = !lastStep;
			end
			default: nextState = controlPkg::seqHalted;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN)
			state <= controlPkg::seqRun;
		else
			state <= nextState;
	end

	assign halted = (state == controlPkg::seqHalted);

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input  logic Clock,
	input  logic rstN,
	output logic memReq,
	output logic memWrite,
	output cpuTypesPkg::memAddr memAddr,
	output cpuTypesPkg::word memWriteData,
	input  logic memAck,
	input  cpuTypesPkg::word memReadData,
	output logic halted
);

	controlPkg::busSource busSel;
	controlPkg::regField regSel;
	controlPkg::aluOp aluSel;
	controlPkg::tStep step;
	cpuTypesPkg::opcode currentOp;
	cpuTypesPkg::word busValue;
	cpuTypesPkg::word mdrValue;
	logic regIn, yIn, zIn, pcIn, irIn;
	logic marIn, mdrLoadBus, memStart;
	logic writeStrobe;  // Sequencer asks for a write access
	logic memDone, advance, clear;

	busDatapath datapath_i (
		.Clock(Clock), .rstN(rstN), .busSel(busSel), .regSel(regSel),
		.regIn(regIn), .yIn(yIn), .zIn(zIn), .pcIn(pcIn), .irIn(irIn),
		.aluSel(aluSel), .mdrValue(mdrValue), .busValue(busValue), .currentOp(currentOp)
	);

	memoryInterface memory_i (
		.Clock(Clock), .rstN(rstN), .busValue(busValue), .marIn(marIn),
		.mdrLoadBus(mdrLoadBus), .memStart(memStart), .memWrite(writeStrobe),
		.mdrValue(mdrValue), .memDone(memDone), .memReq(memReq), .memWriteOut(memWrite),
		.memAddr(memAddr), .memWriteData(memWriteData), .memAck(memAck),
		.memReadData(memReadData)
	);

	controlSequencer sequencer_i (
		.Clock(Clock), .rstN(rstN), .step(step), .currentOp(currentOp), .memDone(memDone),
		.busSel(busSel), .regSel(regSel), .aluSel(aluSel), .regIn(regIn), .yIn(yIn),
		.zIn(zIn), .pcIn(pcIn), .irIn(irIn), .marIn(marIn), .mdrLoadBus(mdrLoadBus),
		.memStart(memStart), .memWrite(writeStrobe), .advance(advance), .clear(clear),
		.halted(halted)
	);

	stepCounter steps_i (
		.Clock(Clock), .rstN(rstN), .advance(advance), .clear(clear), .step(step)
	);

endmodule

// File: source/cpuTypesPkg.sv
`include "cpu_params.svh"

package cpuTypesPkg;

	typedef logic [`CPU_WORD_WIDTH-1:0] word;
	typedef logic [`CPU_ADDR_WIDTH-1:0] memAddr;
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex;

	// Major opcode held in IR bits 31..27
	typedef enum logic [4:0] {
		opLd   = 5'b00000,
		opLdi  = 5'b00001,
		opSt   = 5'b00010,
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opAnd  = 5'b00101,
		opOr   = 5'b00110,
		opShr  = 5'b00111,
		opShl  = 5'b01000,
		opHalt = 5'b11011
	} opcode;

endpackage

// File: source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Width of every data and instruction word
`define CPU_WORD_WIDTH 32

// Memory is word addressed
`define CPU_ADDR_WIDTH 8

`define CPU_REG_COUNT 16

`endif

// File: source/memoryInterface.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module memoryInterface (
	input  logic Clock,
	input  logic rstN,
	input  cpuTypesPkg::word busValue,
	input  logic marIn,
	input  logic mdrLoadBus,
	input  logic memStart,
	input  logic memWrite,
	output cpuTypesPkg::word mdrValue,
	output logic memDone,
	output logic memReq,
	output logic memWriteOut,
	output cpuTypesPkg::memAddr memAddr,
	output cpuTypesPkg::word memWriteData,
	input  logic memAck,
	input  cpuTypesPkg::word memReadData
);

	typedef enum logic [1:0] {phIdle, phRequest, phRelease} memPhase;

	memPhase phase;
	cpuTypesPkg::memAddr mar;
	cpuTypesPkg::word mdr;

	// ############################################################
	// Four-phase master

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			phase <= phIdle;
			memWriteOut <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (phase)
				phIdle: if (memStart) begin
					phase <= phRequest;
					memWriteOut <= memWrite;
				end
				phRequest: if (memAck)
					phase <= phRelease;
				phRelease: if (!memAck) begin
					phase <= phIdle;
					memDone <= 1'b1;  // Return to zero is complete
				end
				default: phase <= phIdle;
			endcase
		end
	end

	// MAR and MDR
	always_ff @(posedge Clock) begin
		if (marIn)
			mar <= busValue[`CPU_ADDR_WIDTH-1:0];
		if (mdrLoadBus)
			mdr <= busValue;
		else if (phase == phRequest && memAck && !memWriteOut)
			mdr <= memReadData;  // Read data is taken as ack rises
	end

	assign memReq = (phase == phRequest);
	assign memAddr = mar;
	assign memWriteData = mdr;
	assign mdrValue = mdr;

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

`include "cpu_params.svh"

module registerFile (
	input  logic Clock,
	input  logic rstN,
	input  cpuTypesPkg::regIndex readIndex,
	input  cpuTypesPkg::regIndex writeIndex,
	input  logic writeEnable,
	input  cpuTypesPkg::word writeData,
	output cpuTypesPkg::word readData
);

	cpuTypesPkg::word regs [`CPU_REG_COUNT];

	// ############################################################
	// Write port

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeEnable) begin
			regs[writeIndex] <= writeData;
		end
	end

	// ############################################################
	// Read port

	assign readData = regs[readIndex];  // Combinational so the bus sees it in the same step

endmodule

// File: source/stepCounter.sv
`timescale 1ns/1ps

module stepCounter (
	input  logic Clock,
	input  logic rstN,
	input  logic advance,
	input  logic clear,
	output controlPkg::tStep step
);

	always_ff @(posedge Clock) begin
		if (!rstN)
			step <= controlPkg::T0;
		else if (clear)
			step <= controlPkg::T0;  // Clear wins over advance
		else if (advance)
			step <= step + 3'd1;
	end

endmodule
